/* bench/periph_assertions.sv */
`timescale 1ns/100ps

module periph_assertions import periph_pkg::*; (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   psel_i,
    input logic                   penable_i,
    input logic                   pwrite_i,
    input logic [data_width-1:0]  prdata_o,
    input logic                   pready_o,
    input logic                   pslverr_o,
    input logic [num_targets-1:0] eip_o
);

    // ----------------------------------------------------------------------
    // Bus response
    // ----------------------------------------------------------------------
    resp_in_access: assert property (@(posedge clk_i)
        (pready_o || pslverr_o) |-> (psel_i && penable_i))
        else $error("pready or pslverr high outside an access cycle");

    // Zero wait states
    ready_in_access: assert property (@(posedge clk_i)
        (psel_i && penable_i) |-> pready_o)
        else $error("pready low in an access cycle");

    err_read_word: assert property (@(posedge clk_i)
        (pslverr_o && !pwrite_i) |-> (prdata_o == err_rdata))
        else $error("error read did not return the error word");

    // ----------------------------------------------------------------------
    // Interrupt outputs
    // ----------------------------------------------------------------------
    eip_in_reset: assert property (@(posedge clk_i)
        (rst_i && $past(rst_i)) |-> (eip_o == '0))
        else $error("eip high during reset");

endmodule

/* bench/periph_tb.sv */
`timescale 1ns/100ps

module periph_tb import periph_pkg::*; ();

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [addr_width-1:0]   paddr;
    logic [data_width-1:0]   pwdata;
    logic [num_ext_irqs-1:0] ext_irq;
    logic [data_width-1:0]   prdata;
    logic                    pready;
    logic                    pslverr;
    logic [num_targets-1:0]  eip;

    // Reference model, indexed by source ID
    logic [prio_width-1:0] m_prio [1:num_sources];
    logic [num_sources:1]  m_ie   [num_targets];
    logic [prio_width-1:0] m_thr  [num_targets];
    logic [num_sources:1]  m_pend;
    logic [num_sources:1]  m_flight;
    logic [num_sources:1]  m_level;

    tb_clock i_clock (
        .clk_o ( clk )
    );

    periph_subsystem UUT (
        .clk_i     ( clk     ),
        .rst_i     ( rst     ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .ext_irq_i ( ext_irq ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .eip_o     ( eip     )
    );

    bind periph_subsystem periph_assertions i_assertions (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .eip_o     ( eip_o     )
    );

    function automatic logic [addr_width-1:0] claim_addr(input int t);
        return {slot_plic, plic_target_off + 12'(16 * t + 4)};
    endfunction

    function automatic logic [addr_width-1:0] timer_addr(input int ch,
                                                         input logic [3:0] off);
        return {slot_timer, 8'(ch), off};
    endfunction

    // Highest priority above threshold, lowest ID first on a tie
    function automatic int model_winner(input int t);
        int p;
        int i;
        for (p = max_priority; p > int'(m_thr[t]); p--) begin
            for (i = 1; i <= num_sources; i++) begin
                if (m_pend[i] && m_ie[t][i] && int'(m_prio[i]) == p) begin
                    return i;
                end
            end
        end
        return 0;
    endfunction

    function automatic void model_gateway();
        int i;
        for (i = 1; i <= num_sources; i++) begin
            if (m_level[i] && !m_flight[i]) begin
                m_pend[i] = 1'b1;
            end
        end
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [data_width-1:0] got,
                               input logic [data_width-1:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic bus_transfer(input logic write, input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] wdata, input logic exp_err,
                                output logic [data_width-1:0] rdata);
        int waited;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waited  = 0;
        // Sample once the access cycle has settled
        #1;
        while (!pready && waited < 4) begin
            @(posedge clk);
            #2;
            waited++;
        end
        assert (pready) else begin
            stop_run($sformatf("Timed out at %0t ns waiting for pready at %h", $time, addr));
        end
        check_value($sformatf("pslverr at %h", addr), 32'(pslverr), 32'(exp_err));
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] wdata);
        logic [data_width-1:0] ignored;
        bus_transfer(1'b1, addr, wdata, 1'b0, ignored);
    endtask

    task automatic read_expect(input string what, input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] exp);
        logic [data_width-1:0] rdata;
        bus_transfer(1'b0, addr, '0, 1'b0, rdata);
        check_value(what, rdata, exp);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_eip();
        int t;
        for (t = 0; t < num_targets; t++) begin
            check_value($sformatf("eip[%0d]", t), 32'(eip[t]), 32'(model_winner(t) != 0));
        end
    endtask

    initial begin
        logic [data_width-1:0] wdata;
        logic [data_width-1:0] rdata;
        logic [addr_width-1:0] addr;
        logic                  wr;
        logic                  matched;
        int                    n;
        int                    t;
        int                    id;
        int                    ch;
        int                    cmp;
        int                    polls;
        int                    guard;

        void'($urandom(32'h213e));
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        ext_irq  = '0;
        m_pend   = '0;
        m_flight = '0;
        m_level  = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // ------------------------------------------------------------------
        // Register readback
        // ------------------------------------------------------------------
        for (id = 1; id <= num_sources; id++) begin
            wdata = $urandom;
            write_reg({slot_plic, 12'(4 * id)}, wdata);
            m_prio[id] = wdata[prio_width-1:0];
            read_expect("priority", {slot_plic, 12'(4 * id)}, 32'(m_prio[id]));
        end
        for (t = 0; t < num_targets; t++) begin
            wdata = $urandom;
            write_reg({slot_plic, plic_enable_off + 12'(4 * t)}, wdata);
            m_ie[t] = wdata[num_sources:1];
            read_expect("enable", {slot_plic, plic_enable_off + 12'(4 * t)}, wdata & 32'h1e);
            wdata = $urandom;
            write_reg({slot_plic, plic_target_off + 12'(16 * t)}, wdata);
            m_thr[t] = wdata[prio_width-1:0];
            read_expect("threshold", {slot_plic, plic_target_off + 12'(16 * t)},
                        32'(m_thr[t]));
        end
        for (ch = 0; ch < num_timers; ch++) begin
            // Far above any count reached before the channel is stopped again
            wdata = $urandom | 32'h0010_0000;
            write_reg(timer_addr(ch, timer_cmp_off), wdata);
            read_expect("timer compare", timer_addr(ch, timer_cmp_off), wdata);
            wdata = $urandom;
            write_reg(timer_addr(ch, timer_ctrl_off), wdata);
            read_expect("timer ctrl", timer_addr(ch, timer_ctrl_off), wdata & 32'h1);
            write_reg(timer_addr(ch, timer_ctrl_off), 32'h0);
            write_reg(timer_addr(ch, timer_cnt_off), 32'h0);
        end

        // ------------------------------------------------------------------
        // Absent slots and error response
        // ------------------------------------------------------------------
        for (n = 0; n < 24; n++) begin
            addr  = {4'($urandom_range(2, 15)), 12'($urandom)};
            wdata = $urandom;
            wr    = 1'($urandom);
            bus_transfer(wr, addr, wdata, 1'b1, rdata);
            if (!wr) begin
                check_value($sformatf("absent read at %h", addr), rdata, err_rdata);
            end
            id = $urandom_range(1, num_sources);
            read_expect("priority", {slot_plic, 12'(4 * id)}, 32'(m_prio[id]));
        end

        // ------------------------------------------------------------------
        // Timer match into the PLIC
        // ------------------------------------------------------------------
        for (ch = 0; ch < num_timers; ch++) begin
            cmp = $urandom_range(20, 200);
            write_reg(timer_addr(ch, timer_cnt_off), 32'h0);
            write_reg(timer_addr(ch, timer_cmp_off), 32'(cmp));
            write_reg(timer_addr(ch, timer_ctrl_off), 32'h1);
            matched = 1'b0;
            polls   = 0;
            // Each status read takes two cycles
            while (!matched && 2 * polls < cmp + 5) begin
                bus_transfer(1'b0, timer_addr(ch, timer_stat_off), '0, 1'b0, rdata);
                matched = rdata[0];
                polls++;
            end
            assert (matched) else begin
                stop_run($sformatf("Timer %0d match flag not set by %0t ns", ch, $time));
            end
            write_reg(timer_addr(ch, timer_ctrl_off), 32'h0);
            write_reg(timer_addr(ch, timer_stat_off), 32'h1);
            read_expect("timer status", timer_addr(ch, timer_stat_off), 32'h0);
            m_level[num_ext_irqs + 1 + ch] = 1'b1;
            model_gateway();
            m_level[num_ext_irqs + 1 + ch] = 1'b0;
            read_expect("pending", {slot_plic, plic_pending_off}, 32'({m_pend, 1'b0}));
        end

        // ------------------------------------------------------------------
        // Claim order, complete and re-pend
        // ------------------------------------------------------------------
        for (n = 0; n < 16; n++) begin
            for (id = 1; id <= num_sources; id++) begin
                m_prio[id] = 3'($urandom);
                write_reg({slot_plic, 12'(4 * id)}, 32'(m_prio[id]));
            end
            for (t = 0; t < num_targets; t++) begin
                m_ie[t]  = 4'($urandom);
                m_thr[t] = 3'($urandom_range(0, 3));
                write_reg({slot_plic, plic_enable_off + 12'(4 * t)}, 32'({m_ie[t], 1'b0}));
                write_reg({slot_plic, plic_target_off + 12'(16 * t)}, 32'(m_thr[t]));
            end
            ext_irq = 2'($urandom);
            m_level[num_ext_irqs:1] = ext_irq;
            idle_cycles(2);
            model_gateway();
            check_eip();

            t     = $urandom_range(0, num_targets - 1);
            guard = 0;
            do begin
                id = model_winner(t);
                read_expect($sformatf("claim on target %0d", t), claim_addr(t), 32'(id));
                if (id != 0) begin
                    m_pend[id]   = 1'b0;
                    m_flight[id] = 1'b1;
                end
                guard++;
            end while (id != 0 && guard <= num_sources);
            idle_cycles(1);
            check_eip();

            // New levels decide which completed sources come back
            ext_irq = 2'($urandom);
            m_level[num_ext_irqs:1] = ext_irq;
            idle_cycles(2);
            model_gateway();
            for (id = 1; id <= num_sources; id++) begin
                if (m_flight[id]) begin
                    write_reg(claim_addr(0), 32'(id));
                    m_flight[id] = 1'b0;
                    model_gateway();
                end
            end
            read_expect("pending", {slot_plic, plic_pending_off}, 32'({m_pend, 1'b0}));
            check_eip();
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // 10 ns period
    always begin
        #5 clk_o = ~clk_o;
    end

endmodule

/* build.f */
design/periph_pkg.sv
design/apb_slot_decode.sv
design/apb_timer_unit.sv
design/irq_controller.sv
design/periph_subsystem.sv
bench/tb_clock.sv
bench/periph_assertions.sv
bench/periph_tb.sv

/* design/apb_slot_decode.sv */
`timescale 1ns/100ps

module apb_slot_decode import periph_pkg::*; (
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [addr_width-1:0] paddr_i,
    input  logic [data_width-1:0] plic_rdata_i,
    input  logic [data_width-1:0] timer_rdata_i,
    output logic                  sel_plic_o,
    output logic                  sel_timer_o,
    output logic [data_width-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    logic [slot_width-1:0] slot;
    logic                  access;
    logic                  slot_absent;
    logic [data_width-1:0] slot_rdata;

    assign slot   = paddr_i[addr_width-1:slot_lsb];
    assign access = psel_i & penable_i;

    always_comb begin
        slot_absent = 1'b0;
        slot_rdata  = err_rdata;
        case (slot)
            slot_plic:  slot_rdata = plic_rdata_i;
            slot_timer: slot_rdata = timer_rdata_i;
            // SPI and Ethernet are not built in
            slot_spi, slot_eth: slot_absent = 1'b1;
            default:    slot_absent = 1'b1;
        endcase
    end

    assign sel_plic_o  = psel_i && (slot == slot_plic);
    assign sel_timer_o = psel_i && (slot == slot_timer);

    // Zero wait states
    assign pready_o  = access;
    assign pslverr_o = access & slot_absent;

    // Read word only matters on reads
    assign prdata_o = pwrite_i ? '0 : slot_rdata;

endmodule

/* design/apb_timer_unit.sv */
`timescale 1ns/100ps

module apb_timer_unit import periph_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  sel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [addr_width-1:0] paddr_i,
    input  logic [data_width-1:0] pwdata_i,
    output logic [data_width-1:0] rdata_o,
    output logic [num_timers-1:0] irq_o
);

    logic [data_width-1:0]               count   [num_timers];
    logic [data_width-1:0]               compare [num_timers];
    logic [num_timers-1:0]               enable;
    logic [num_timers-1:0]               match;
    logic [slot_lsb-timer_blk_lsb-1:0]   blk;
    logic [timer_blk_lsb-1:0]            reg_off;
    logic                                wr_en;

    assign blk     = paddr_i[slot_lsb-1:timer_blk_lsb];
    assign reg_off = paddr_i[timer_blk_lsb-1:0];
    assign wr_en   = sel_i & penable_i & pwrite_i;

    // ----------------------------------------------------------------------
    // Counters and registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int ch = 0; ch < num_timers; ch++) begin
                count[ch]   <= '0;
                compare[ch] <= '0;
            end
            enable <= '0;
            match  <= '0;
        end else begin
            for (int ch = 0; ch < num_timers; ch++) begin
                if (enable[ch]) begin
                    // Wrap on compare
                    if (count[ch] == compare[ch]) begin
                        count[ch] <= '0;
                        match[ch] <= 1'b1;
                    end else begin
                        count[ch] <= count[ch] + data_width'(1);
                    end
                end
                // Later assignments win over the count update
                if (wr_en && int'(blk) == ch) begin
                    case (reg_off)
                        timer_cnt_off:  count[ch]   <= pwdata_i;
                        timer_cmp_off:  compare[ch] <= pwdata_i;
                        timer_ctrl_off: enable[ch]  <= pwdata_i[0];
                        timer_stat_off: begin
                            if (pwdata_i[0]) begin
                                match[ch] <= 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read path
    // ----------------------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        for (int ch = 0; ch < num_timers; ch++) begin
            if (int'(blk) == ch) begin
                case (reg_off)
                    timer_cnt_off:  rdata_o = count[ch];
                    timer_cmp_off:  rdata_o = compare[ch];
                    timer_ctrl_off: rdata_o = data_width'(enable[ch]);
                    timer_stat_off: rdata_o = data_width'(match[ch]);
                    default:        rdata_o = '0;
                endcase
            end
        end
    end

    // Sticky flag is the interrupt level
    assign irq_o = match;

endmodule

/* design/irq_controller.sv */
`timescale 1ns/100ps

module irq_controller import periph_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   sel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [addr_width-1:0]  paddr_i,
    input  logic [data_width-1:0]  pwdata_i,
    input  logic [num_sources-1:0] irq_sources_i,
    output logic [data_width-1:0]  rdata_o,
    output logic [num_targets-1:0] eip_o
);

    // Per source state, IDs start at 1
    logic [prio_width-1:0] prio [1:num_sources];
    logic [num_sources:1]  pending;
    logic [num_sources:1]  in_flight;

    // Per target state
    logic [num_sources:1]  ie        [num_targets];
    logic [prio_width-1:0] threshold [num_targets];
    logic [id_width-1:0]   cand_id   [num_targets];
    logic [slot_lsb-1:0]   ie_addr   [num_targets];
    logic [slot_lsb-1:0]   thr_addr  [num_targets];
    logic [slot_lsb-1:0]   claim_addr [num_targets];

    logic [slot_lsb-1:0] offset;
    logic [id_width-1:0] done_id;
    logic                wr_en;
    logic                rd_en;
    logic                done_valid;

    assign offset     = paddr_i[slot_lsb-1:0];
    assign wr_en      = sel_i & penable_i & pwrite_i;
    assign rd_en      = sel_i & penable_i & ~pwrite_i;
    assign done_id    = pwdata_i[id_width-1:0];
    assign done_valid = (done_id != '0) && (int'(done_id) <= num_sources);

    always_comb begin
        for (int t = 0; t < num_targets; t++) begin
            ie_addr[t]    = plic_enable_off + slot_lsb'(4 * t);
            thr_addr[t]   = plic_target_off + slot_lsb'(16 * t);
            claim_addr[t] = plic_target_off + slot_lsb'(16 * t + 4);
        end
    end

    // ----------------------------------------------------------------------
    // Arbitration, strict compare keeps the lowest ID on a tie
    // ----------------------------------------------------------------------
    always_comb begin
        logic [prio_width-1:0] best;
        for (int t = 0; t < num_targets; t++) begin
            best       = threshold[t];
            cand_id[t] = '0;
            for (int i = 1; i <= num_sources; i++) begin
                if (pending[i] && ie[t][i] && prio[i] > best) begin
                    best       = prio[i];
                    cand_id[t] = id_width'(i);
                end
            end
            eip_o[t] = (cand_id[t] != '0);
        end
    end

    // ----------------------------------------------------------------------
    // Gateways and registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i <= num_sources; i++) begin
                prio[i] <= '0;
            end
            for (int t = 0; t < num_targets; t++) begin
                ie[t]        <= '0;
                threshold[t] <= '0;
            end
            pending   <= '0;
            in_flight <= '0;
        end else begin
            for (int i = 1; i <= num_sources; i++) begin
                // Level gateway, one request per claim/complete round
                if (irq_sources_i[i-1] && !pending[i] && !in_flight[i]) begin
                    pending[i] <= 1'b1;
                end
                if (wr_en && offset == slot_lsb'(4 * i)) begin
                    prio[i] <= pwdata_i[prio_width-1:0];
                end
            end
            for (int t = 0; t < num_targets; t++) begin
                if (rd_en && offset == claim_addr[t] && cand_id[t] != '0) begin
                    pending[cand_id[t]]   <= 1'b0;
                    in_flight[cand_id[t]] <= 1'b1;
                end
                if (wr_en && offset == ie_addr[t]) begin
                    ie[t] <= pwdata_i[num_sources:1];
                end
                if (wr_en && offset == thr_addr[t]) begin
                    threshold[t] <= pwdata_i[prio_width-1:0];
                end
                if (wr_en && offset == claim_addr[t] && done_valid) begin
                    in_flight[done_id] <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read path
    // ----------------------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (offset == plic_pending_off) begin
            rdata_o = data_width'({pending, 1'b0});
        end
        for (int i = 1; i <= num_sources; i++) begin
            if (offset == slot_lsb'(4 * i)) begin
                rdata_o = data_width'(prio[i]);
            end
        end
        for (int t = 0; t < num_targets; t++) begin
            if (offset == ie_addr[t]) begin
                rdata_o = data_width'({ie[t], 1'b0});
            end
            if (offset == thr_addr[t]) begin
                rdata_o = data_width'(threshold[t]);
            end
            // Claim returns the current winner
            if (offset == claim_addr[t]) begin
                rdata_o = data_width'(cand_id[t]);
            end
        end
    end

endmodule

/* design/periph_pkg.sv */
package periph_pkg;

    // ----------------------------------------------------------------------
    // Bus
    // ----------------------------------------------------------------------
    localparam int addr_width = 16;
    localparam int data_width = 32;

    // ----------------------------------------------------------------------
    // Address map, slot field is paddr[15:12]
    // ----------------------------------------------------------------------
    localparam int slot_lsb   = 12;
    localparam int slot_width = addr_width - slot_lsb;

    localparam logic [slot_width-1:0] slot_plic  = slot_width'(0);
    localparam logic [slot_width-1:0] slot_timer = slot_width'(1);
    localparam logic [slot_width-1:0] slot_spi   = slot_width'(2);
    localparam logic [slot_width-1:0] slot_eth   = slot_width'(3);

    // Read word of an absent slot
    localparam logic [data_width-1:0] err_rdata = 32'hdeadbeef;

    // ----------------------------------------------------------------------
    // Interrupts
    // ----------------------------------------------------------------------
    localparam int num_sources  = 4;
    localparam int num_targets  = 2;
    localparam int num_timers   = 2;
    localparam int num_ext_irqs = num_sources - num_timers;
    localparam int max_priority = 7;
    localparam int prio_width   = $clog2(max_priority + 1);
    localparam int id_width     = $clog2(num_sources + 1);

    // PLIC register offsets inside its slot
    localparam logic [slot_lsb-1:0] plic_pending_off = 12'h080;
    localparam logic [slot_lsb-1:0] plic_enable_off  = 12'h100;
    localparam logic [slot_lsb-1:0] plic_target_off  = 12'h200;

    // Timer, one 0x10 byte block per channel
    localparam int timer_blk_lsb = 4;
    localparam logic [timer_blk_lsb-1:0] timer_cnt_off  = 4'h0;
    localparam logic [timer_blk_lsb-1:0] timer_cmp_off  = 4'h4;
    localparam logic [timer_blk_lsb-1:0] timer_ctrl_off = 4'h8;
    localparam logic [timer_blk_lsb-1:0] timer_stat_off = 4'hc;

endpackage

/* design/periph_subsystem.sv */
`timescale 1ns/100ps

module periph_subsystem import periph_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [addr_width-1:0]   paddr_i,
    input  logic [data_width-1:0]   pwdata_i,
    input  logic [num_ext_irqs-1:0] ext_irq_i,
    output logic [data_width-1:0]   prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output logic [num_targets-1:0]  eip_o
);

    logic                  sel_plic;
    logic                  sel_timer;
    logic [data_width-1:0] plic_rdata;
    logic [data_width-1:0] timer_rdata;
    logic [num_timers-1:0] timer_irq;

    // ----------------------------------------------------------------------
    // Slot decode and error response
    // ----------------------------------------------------------------------
    apb_slot_decode i_slot_decode (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .plic_rdata_i  ( plic_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .sel_plic_o    ( sel_plic    ),
        .sel_timer_o   ( sel_timer   ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    // ----------------------------------------------------------------------
    // Timer
    // ----------------------------------------------------------------------
    apb_timer_unit i_timer (
        .clk_i     ( clk_i       ),
        .rst_i     ( rst_i       ),
        .sel_i     ( sel_timer   ),
        .penable_i ( penable_i   ),
        .pwrite_i  ( pwrite_i    ),
        .paddr_i   ( paddr_i     ),
        .pwdata_i  ( pwdata_i    ),
        .rdata_o   ( timer_rdata ),
        .irq_o     ( timer_irq   )
    );

    // ----------------------------------------------------------------------
    // PLIC, IDs 1-2 external lines, IDs 3-4 timer channels
    // ----------------------------------------------------------------------
    irq_controller i_plic (
        .clk_i         ( clk_i                  ),
        .rst_i         ( rst_i                  ),
        .sel_i         ( sel_plic               ),
        .penable_i     ( penable_i              ),
        .pwrite_i      ( pwrite_i               ),
        .paddr_i       ( paddr_i                ),
        .pwdata_i      ( pwdata_i               ),
        .irq_sources_i ( {timer_irq, ext_irq_i} ),
        .rdata_o       ( plic_rdata             ),
        .eip_o         ( eip_o                  )
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module periph_tb -o periph_sim

sim_out=$(./obj_dir/periph_sim || true)
echo "$sim_out"

if grep -q "SIMULATION PASSED" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
